/* source/pbs_pkg.sv */
// Shared sizes and types for the bootstrap entry side
// Imported by every RTL module that needs ring, slot, digit or counter widths

package pbs_pkg;

  // --------------------------------------------------------------------------
  // Ring and coefficient sizes
  // --------------------------------------------------------------------------
  localparam int POLY_N     = 16;
  localparam int COEF_IDX_W = 4;
  // Modulus is 2^COEF_W
  localparam int COEF_W     = 16;

  // GLWE slots, RAM address is {slot, coefficient index}
  localparam int SLOT_NB    = 4;
  localparam int SLOT_W     = 2;
  localparam int GRAM_ADD_W = SLOT_W + COEF_IDX_W;

  // Rotation covers 0 to 2N-1
  localparam int ROT_W      = COEF_IDX_W + 1;

  // --------------------------------------------------------------------------
  // Decomposition
  // --------------------------------------------------------------------------
  localparam int PBS_B_W    = 4;
  localparam int PBS_L      = 2;
  // Two's complement digit
  localparam int DIGIT_W    = PBS_B_W + 1;
  localparam int LVL_W      = $clog2(PBS_L);
  localparam int KEPT_W     = PBS_L * PBS_B_W;
  localparam int DROP_W     = COEF_W - KEPT_W;

  localparam int PBS_ID_W   = 4;

  // Feed FSM encoding
  localparam int               FEED_ST_W = 2;
  localparam [FEED_ST_W-1:0]   FEED_IDLE = 2'd0;
  localparam [FEED_ST_W-1:0]   FEED_ROT  = 2'd1;
  localparam [FEED_ST_W-1:0]   FEED_OUT  = 2'd2;

  // Status
  localparam int CNT_W         = 8;
  localparam int ERR_W         = 4;
  // Feed on a slot that was never loaded
  localparam int ERR_FEED_SLOT = 0;

  // Coefficient seen either whole or split for rounding
  typedef struct packed {
    logic [KEPT_W-1:0] kept;
    logic [DROP_W-1:0] dropped;
  } coef_split_t;

  typedef union packed {
    logic [COEF_W-1:0] coef;
    coef_split_t       split;
  } coef_u;

endpackage

/* source/glwe_loader.sv */
// GLWE load engine
// Takes a slot command, then writes POLY_N streamed coefficients into the
// GLWE RAM and flags the slot as loaded

`timescale 1ns/1ps

module glwe_loader
  import pbs_pkg::*;
(
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  ldg_cmd_vld,
  output logic                  ldg_cmd_rdy,
  input  logic [SLOT_W-1:0]     ldg_cmd_slot,

  input  logic                  ldg_data_vld,
  output logic                  ldg_data_rdy,
  input  logic [COEF_W-1:0]     ldg_data,

  output logic                  gram_wr_en,
  output logic [GRAM_ADD_W-1:0] gram_wr_add,
  output logic [COEF_W-1:0]     gram_wr_data,

  output logic                  ldg_done,
  output logic [SLOT_NB-1:0]    slot_loaded
);

  logic                  loading;
  logic [SLOT_W-1:0]     slot_q;
  logic [COEF_IDX_W-1:0] idx;
  logic                  cmd_xfer;
  logic                  data_xfer;
  logic                  last_xfer;

  assign ldg_cmd_rdy  = ~loading;
  assign ldg_data_rdy = loading;

  assign cmd_xfer  = ldg_cmd_vld & ldg_cmd_rdy;
  assign data_xfer = ldg_data_vld & ldg_data_rdy;
  assign last_xfer = data_xfer & (idx == COEF_IDX_W'(POLY_N - 1));

  // Write straight through in the transfer cycle
  assign gram_wr_en   = data_xfer;
  assign gram_wr_add  = {slot_q, idx};
  assign gram_wr_data = ldg_data;

  // --------------------------------------------------------------------------
  // Idle / loading FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      loading     <= 1'b0;
      idx         <= '0;
      ldg_done    <= 1'b0;
      slot_loaded <= '0;
    end else begin
      ldg_done <= last_xfer;
      if (cmd_xfer) begin
        loading <= 1'b1;
        idx     <= '0;
      end else if (data_xfer) begin
        idx <= idx + 1'b1;
        if (last_xfer) begin
          loading             <= 1'b0;
          slot_loaded[slot_q] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_xfer) begin
      slot_q <= ldg_cmd_slot;
    end
  end

endmodule

/* source/glwe_ram.sv */
// GLWE coefficient memory, four slots of POLY_N words
// One write port, one read port with a single cycle of read latency

`timescale 1ns/1ps

module glwe_ram
  import pbs_pkg::*;
(
  input  logic                  clk,

  input  logic                  wr_en,
  input  logic [GRAM_ADD_W-1:0] wr_add,
  input  logic [COEF_W-1:0]     wr_data,

  input  logic                  rd_en,
  input  logic [GRAM_ADD_W-1:0] rd_add,
  output logic [COEF_W-1:0]     rd_data
);

  logic [COEF_W-1:0] mem [0:(1 << GRAM_ADD_W)-1];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_add] <= wr_data;
    end
  end

  // Registered read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_add];
    end
  end

endmodule

/* source/mono_mult_acc.sv */
// Monomial multiply-accumulate
// Multiplies a stored slot by X^rot in the negacyclic ring, overwrites or adds
// into the accumulator, and streams the accumulator out on a last command

`timescale 1ns/1ps

module mono_mult_acc
  import pbs_pkg::*;
(
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  feed_cmd_vld,
  output logic                  feed_cmd_rdy,
  input  logic [SLOT_W-1:0]     feed_cmd_slot,
  input  logic [ROT_W-1:0]      feed_cmd_rot,
  input  logic                  feed_cmd_first,
  input  logic                  feed_cmd_last,
  input  logic [PBS_ID_W-1:0]   feed_cmd_pbs_id,
  output logic                  feed_ack,
  output logic                  feed_slot_error,

  output logic                  gram_rd_en,
  output logic [GRAM_ADD_W-1:0] gram_rd_add,
  input  logic [COEF_W-1:0]     gram_rd_data,
  input  logic [SLOT_NB-1:0]    slot_loaded,

  output logic                  acc_decomp_vld,
  input  logic                  acc_decomp_rdy,
  output logic [COEF_W-1:0]     acc_decomp_coef,
  output logic                  acc_decomp_last,
  output logic [PBS_ID_W-1:0]   acc_decomp_pbs_id
);

  logic [FEED_ST_W-1:0]  state;
  logic [COEF_IDX_W:0]   cnt;
  logic                  cmd_xfer;
  logic                  rot_end;
  logic                  out_xfer;

  // Command fields held for the whole command
  logic [SLOT_W-1:0]     slot_q;
  logic [ROT_W-1:0]      rot_q;
  logic                  first_q;
  logic                  last_q;
  logic [PBS_ID_W-1:0]   pbs_id_q;

  // Read pipeline, aligned with gram_rd_data
  logic                  rd_vld_q;
  logic [COEF_IDX_W-1:0] rd_idx_q;
  logic [ROT_W-1:0]      pos;
  logic [COEF_IDX_W-1:0] dest;
  logic [COEF_W-1:0]     rot_val;

  logic [COEF_W-1:0]     acc [0:POLY_N-1];

  assign feed_cmd_rdy = (state == FEED_IDLE);
  assign cmd_xfer     = feed_cmd_vld & feed_cmd_rdy;
  assign rot_end      = (state == FEED_ROT) && (cnt == (COEF_IDX_W + 1)'(POLY_N));

  // One read per cycle, the extra rotate cycle drains the RAM latency
  assign gram_rd_en  = (state == FEED_ROT) && !cnt[COEF_IDX_W];
  assign gram_rd_add = {slot_q, cnt[COEF_IDX_W-1:0]};

  // --------------------------------------------------------------------------
  // Negacyclic destination, position wraps modulo 2N
  // --------------------------------------------------------------------------
  assign pos     = ROT_W'(rd_idx_q) + rot_q;
  assign dest    = pos[COEF_IDX_W-1:0];
  assign rot_val = pos[ROT_W-1] ? -gram_rd_data : gram_rd_data;

  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      acc[dest] <= first_q ? rot_val : acc[dest] + rot_val;
    end
  end

  // Output stream in index order
  assign acc_decomp_vld    = (state == FEED_OUT);
  assign acc_decomp_coef   = acc[cnt[COEF_IDX_W-1:0]];
  assign acc_decomp_last   = (cnt[COEF_IDX_W-1:0] == COEF_IDX_W'(POLY_N - 1));
  assign acc_decomp_pbs_id = pbs_id_q;
  assign out_xfer          = acc_decomp_vld & acc_decomp_rdy;

  // --------------------------------------------------------------------------
  // Feed FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state           <= FEED_IDLE;
      cnt             <= '0;
      rd_vld_q        <= 1'b0;
      feed_ack        <= 1'b0;
      feed_slot_error <= 1'b0;
    end else begin
      rd_vld_q        <= gram_rd_en;
      feed_ack        <= 1'b0;
      feed_slot_error <= cmd_xfer & ~slot_loaded[feed_cmd_slot];
      case (state)
        FEED_IDLE: begin
          if (cmd_xfer) begin
            state <= FEED_ROT;
            cnt   <= '0;
          end
        end
        FEED_ROT: begin
          cnt <= cnt + 1'b1;
          if (rot_end) begin
            cnt <= '0;
            if (last_q) begin
              state <= FEED_OUT;
            end else begin
              state    <= FEED_IDLE;
              feed_ack <= 1'b1;
            end
          end
        end
        FEED_OUT: begin
          if (out_xfer) begin
            cnt <= cnt + 1'b1;
            if (acc_decomp_last) begin
              state    <= FEED_IDLE;
              feed_ack <= 1'b1;
            end
          end
        end
        default: state <= FEED_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rd_idx_q <= cnt[COEF_IDX_W-1:0];
    if (cmd_xfer) begin
      slot_q   <= feed_cmd_slot;
      rot_q    <= feed_cmd_rot;
      first_q  <= feed_cmd_first;
      last_q   <= feed_cmd_last;
      pbs_id_q <= feed_cmd_pbs_id;
    end
  end

endmodule

/* source/decomp_balanced.sv */
// Balanced decomposition of accumulator coefficients
// Rounds each coefficient to its top PBS_L*PBS_B_W bits and emits PBS_L
// signed digits to the NTT side, least significant level first

`timescale 1ns/1ps

module decomp_balanced
  import pbs_pkg::*;
(
  input  logic                clk,
  input  logic                s_rst_n,

  input  logic                acc_decomp_vld,
  output logic                acc_decomp_rdy,
  input  logic [COEF_W-1:0]   acc_decomp_coef,
  input  logic                acc_decomp_last,
  input  logic [PBS_ID_W-1:0] acc_decomp_pbs_id,

  output logic                decomp_ntt_vld,
  input  logic                decomp_ntt_rdy,
  output logic [DIGIT_W-1:0]  decomp_ntt_data,
  output logic                decomp_ntt_sol,
  output logic                decomp_ntt_eol,
  output logic                decomp_ntt_eob,
  output logic [PBS_ID_W-1:0] decomp_ntt_pbs_id
);

  coef_u                           coef_in;
  logic [KEPT_W-1:0]               rnd;
  logic [PBS_L-1:0][DIGIT_W-1:0]   digit_d;
  logic [PBS_L-1:0][DIGIT_W-1:0]   digit_q;
  logic                            eob_q;
  logic [PBS_ID_W-1:0]             pbs_id_q;

  logic                            pend;
  logic [LVL_W-1:0]                lvl;
  logic                            in_xfer;
  logic                            out_xfer;
  logic                            lvl_last;

  // --------------------------------------------------------------------------
  // Rounding, kept part plus the top dropped bit
  // --------------------------------------------------------------------------
  assign coef_in.coef = acc_decomp_coef;
  assign rnd          = coef_in.split.kept + KEPT_W'(coef_in.split.dropped[DROP_W-1]);

  // Nibble of 8 or more goes negative and carries into the next level
  always_comb begin : digit_calc
    logic [PBS_B_W-1:0] nib;
    logic               carry;
    carry = 1'b0;
    for (int l = 0; l < PBS_L; l++) begin
      nib        = rnd[l*PBS_B_W +: PBS_B_W] + PBS_B_W'(carry);
      digit_d[l] = {nib[PBS_B_W-1], nib};
      carry      = nib[PBS_B_W-1];
    end
  end

  assign acc_decomp_rdy = ~pend;
  assign in_xfer        = acc_decomp_vld & acc_decomp_rdy;
  assign out_xfer       = decomp_ntt_vld & decomp_ntt_rdy;
  assign lvl_last       = (lvl == LVL_W'(PBS_L - 1));

  assign decomp_ntt_vld    = pend;
  assign decomp_ntt_data   = digit_q[lvl];
  assign decomp_ntt_sol    = (lvl == '0);
  assign decomp_ntt_eol    = lvl_last;
  assign decomp_ntt_eob    = eob_q;
  assign decomp_ntt_pbs_id = pbs_id_q;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      pend <= 1'b0;
      lvl  <= '0;
    end else if (in_xfer) begin
      pend <= 1'b1;
      lvl  <= '0;
    end else if (out_xfer) begin
      if (lvl_last) begin
        pend <= 1'b0;
        lvl  <= '0;
      end else begin
        lvl <= lvl + 1'b1;
      end
    end
  end

  // Digits stay put until the next accepted coefficient
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      digit_q  <= digit_d;
      eob_q    <= acc_decomp_last;
      pbs_id_q <= acc_decomp_pbs_id;
    end
  end

endmodule

/* source/pbs_event_counter.sv */
// Status block for the entry side
// Counts completed loads and feeds, keeps sticky error flags until reset

`timescale 1ns/1ps

module pbs_event_counter
  import pbs_pkg::*;
(
  input  logic             clk,
  input  logic             s_rst_n,

  input  logic             ldg_done,
  input  logic             feed_ack,
  input  logic             feed_slot_error,

  output logic [CNT_W-1:0] load_count,
  output logic [CNT_W-1:0] feed_count,
  output logic [ERR_W-1:0] error_flags
);

  // Counters wrap
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      load_count <= '0;
      feed_count <= '0;
    end else begin
      if (ldg_done) begin
        load_count <= load_count + 1'b1;
      end
      if (feed_ack) begin
        feed_count <= feed_count + 1'b1;
      end
    end
  end

  // Sticky, unused bits stay at 0
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      error_flags <= '0;
    end else if (feed_slot_error) begin
      error_flags[ERR_FEED_SLOT] <= 1'b1;
    end
  end

endmodule

/* source/pbs_entry_subsidiary.sv */
// Entry side of the bootstrap processing element
// Loader, GLWE RAM, monomial multiply-accumulate, decomposer and status counters

`timescale 1ns/1ps

module pbs_entry_subsidiary
  import pbs_pkg::*;
(
  input  logic                clk,
  input  logic                s_rst_n,

  input  logic                ldg_cmd_vld,
  output logic                ldg_cmd_rdy,
  input  logic [SLOT_W-1:0]   ldg_cmd_slot,
  input  logic                ldg_data_vld,
  output logic                ldg_data_rdy,
  input  logic [COEF_W-1:0]   ldg_data,
  output logic                ldg_done,

  input  logic                feed_cmd_vld,
  output logic                feed_cmd_rdy,
  input  logic [SLOT_W-1:0]   feed_cmd_slot,
  input  logic [ROT_W-1:0]    feed_cmd_rot,
  input  logic                feed_cmd_first,
  input  logic                feed_cmd_last,
  input  logic [PBS_ID_W-1:0] feed_cmd_pbs_id,
  output logic                feed_ack,

  output logic                decomp_ntt_vld,
  input  logic                decomp_ntt_rdy,
  output logic [DIGIT_W-1:0]  decomp_ntt_data,
  output logic                decomp_ntt_sol,
  output logic                decomp_ntt_eol,
  output logic                decomp_ntt_eob,
  output logic [PBS_ID_W-1:0] decomp_ntt_pbs_id,

  output logic [CNT_W-1:0]    load_count,
  output logic [CNT_W-1:0]    feed_count,
  output logic [ERR_W-1:0]    error_flags
);

  // --------------------------------------------------------------------------
  // Internal connections
  // --------------------------------------------------------------------------
  logic                  gram_wr_en;
  logic [GRAM_ADD_W-1:0] gram_wr_add;
  logic [COEF_W-1:0]     gram_wr_data;
  logic                  gram_rd_en;
  logic [GRAM_ADD_W-1:0] gram_rd_add;
  logic [COEF_W-1:0]     gram_rd_data;
  logic [SLOT_NB-1:0]    slot_loaded;
  logic                  feed_slot_error;

  logic                  acc_decomp_vld;
  logic                  acc_decomp_rdy;
  logic [COEF_W-1:0]     acc_decomp_coef;
  logic                  acc_decomp_last;
  logic [PBS_ID_W-1:0]   acc_decomp_pbs_id;

  glwe_loader glwe_loader (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .ldg_cmd_vld  (ldg_cmd_vld),
    .ldg_cmd_rdy  (ldg_cmd_rdy),
    .ldg_cmd_slot (ldg_cmd_slot),
    .ldg_data_vld (ldg_data_vld),
    .ldg_data_rdy (ldg_data_rdy),
    .ldg_data     (ldg_data),
    .gram_wr_en   (gram_wr_en),
    .gram_wr_add  (gram_wr_add),
    .gram_wr_data (gram_wr_data),
    .ldg_done     (ldg_done),
    .slot_loaded  (slot_loaded)
  );

  glwe_ram glwe_ram (
    .clk     (clk),
    .wr_en   (gram_wr_en),
    .wr_add  (gram_wr_add),
    .wr_data (gram_wr_data),
    .rd_en   (gram_rd_en),
    .rd_add  (gram_rd_add),
    .rd_data (gram_rd_data)
  );

  mono_mult_acc mono_mult_acc (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .feed_cmd_vld      (feed_cmd_vld),
    .feed_cmd_rdy      (feed_cmd_rdy),
    .feed_cmd_slot     (feed_cmd_slot),
    .feed_cmd_rot      (feed_cmd_rot),
    .feed_cmd_first    (feed_cmd_first),
    .feed_cmd_last     (feed_cmd_last),
    .feed_cmd_pbs_id   (feed_cmd_pbs_id),
    .feed_ack          (feed_ack),
    .feed_slot_error   (feed_slot_error),
    .gram_rd_en        (gram_rd_en),
    .gram_rd_add       (gram_rd_add),
    .gram_rd_data      (gram_rd_data),
    .slot_loaded       (slot_loaded),
    .acc_decomp_vld    (acc_decomp_vld),
    .acc_decomp_rdy    (acc_decomp_rdy),
    .acc_decomp_coef   (acc_decomp_coef),
    .acc_decomp_last   (acc_decomp_last),
    .acc_decomp_pbs_id (acc_decomp_pbs_id)
  );

  decomp_balanced decomp_balanced (
    .clk               (clk),
    .s_rst_n           (s_rst_n),
    .acc_decomp_vld    (acc_decomp_vld),
    .acc_decomp_rdy    (acc_decomp_rdy),
    .acc_decomp_coef   (acc_decomp_coef),
    .acc_decomp_last   (acc_decomp_last),
    .acc_decomp_pbs_id (acc_decomp_pbs_id),
    .decomp_ntt_vld    (decomp_ntt_vld),
    .decomp_ntt_rdy    (decomp_ntt_rdy),
    .decomp_ntt_data   (decomp_ntt_data),
    .decomp_ntt_sol    (decomp_ntt_sol),
    .decomp_ntt_eol    (decomp_ntt_eol),
    .decomp_ntt_eob    (decomp_ntt_eob),
    .decomp_ntt_pbs_id (decomp_ntt_pbs_id)
  );

  pbs_event_counter pbs_event_counter (
    .clk             (clk),
    .s_rst_n         (s_rst_n),
    .ldg_done        (ldg_done),
    .feed_ack        (feed_ack),
    .feed_slot_error (feed_slot_error),
    .load_count      (load_count),
    .feed_count      (feed_count),
    .error_flags     (error_flags)
  );

endmodule

/* sim/pbs_entry_properties.sv */
// Handshake assertions for the entry side
// Bound into the top level, checks hold-while-stalled, feed command gating and
// quiet valids during reset

`timescale 1ns/1ps

module pbs_entry_properties
  import pbs_pkg::*;
(
  input logic                clk,
  input logic                s_rst_n,
  input logic                ldg_cmd_vld,
  input logic                ldg_cmd_rdy,
  input logic [SLOT_W-1:0]   ldg_cmd_slot,
  input logic                ldg_data_vld,
  input logic                ldg_data_rdy,
  input logic [COEF_W-1:0]   ldg_data,
  input logic                feed_cmd_vld,
  input logic                feed_cmd_rdy,
  input logic [SLOT_W-1:0]   feed_cmd_slot,
  input logic [ROT_W-1:0]    feed_cmd_rot,
  input logic                feed_cmd_first,
  input logic                feed_cmd_last,
  input logic [PBS_ID_W-1:0] feed_cmd_pbs_id,
  input logic                feed_ack,
  input logic                acc_decomp_vld,
  input logic                acc_decomp_rdy,
  input logic [COEF_W-1:0]   acc_decomp_coef,
  input logic                acc_decomp_last,
  input logic [PBS_ID_W-1:0] acc_decomp_pbs_id,
  input logic                decomp_ntt_vld,
  input logic                decomp_ntt_rdy,
  input logic [DIGIT_W-1:0]  decomp_ntt_data,
  input logic                decomp_ntt_sol,
  input logic                decomp_ntt_eol,
  input logic                decomp_ntt_eob,
  input logic [PBS_ID_W-1:0] decomp_ntt_pbs_id
);

  // --------------------------------------------------------------------------
  // Valid and data held until the transfer
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) disable iff (!s_rst_n)
    ldg_cmd_vld && !ldg_cmd_rdy |=> ldg_cmd_vld && $stable(ldg_cmd_slot))
    else $error("Load command changed while stalled");

  assert property (@(posedge clk) disable iff (!s_rst_n)
    ldg_data_vld && !ldg_data_rdy |=> ldg_data_vld && $stable(ldg_data))
    else $error("Load data changed while stalled");

  assert property (@(posedge clk) disable iff (!s_rst_n)
    feed_cmd_vld && !feed_cmd_rdy |=> feed_cmd_vld && $stable({feed_cmd_slot,
      feed_cmd_rot, feed_cmd_first, feed_cmd_last, feed_cmd_pbs_id}))
    else $error("Feed command changed while stalled");

  assert property (@(posedge clk) disable iff (!s_rst_n)
    acc_decomp_vld && !acc_decomp_rdy |=> acc_decomp_vld && $stable({acc_decomp_coef,
      acc_decomp_last, acc_decomp_pbs_id}))
    else $error("Accumulator output changed while stalled");

  assert property (@(posedge clk) disable iff (!s_rst_n)
    decomp_ntt_vld && !decomp_ntt_rdy |=> decomp_ntt_vld && $stable({decomp_ntt_data,
      decomp_ntt_sol, decomp_ntt_eol, decomp_ntt_eob, decomp_ntt_pbs_id}))
    else $error("Digit output changed while stalled");

  // Feed command ready stays low from acceptance up to feed_ack
  assert property (@(posedge clk) disable iff (!s_rst_n)
    feed_cmd_vld && feed_cmd_rdy |=> !feed_cmd_rdy)
    else $error("Feed command ready still high after acceptance");

  assert property (@(posedge clk) disable iff (!s_rst_n)
    $rose(feed_cmd_rdy) |-> feed_ack)
    else $error("Feed command ready returned without feed_ack");

  assert property (@(posedge clk)
    !s_rst_n && !$past(s_rst_n) |-> !(ldg_cmd_vld || ldg_data_vld || feed_cmd_vld ||
      acc_decomp_vld || decomp_ntt_vld))
    else $error("Valid high during reset");

endmodule

bind pbs_entry_subsidiary pbs_entry_properties props (.*);

/* sim/tb_pbs_entry.sv */
// Directed testbench for the bootstrap entry side
// Loads GLWE slots, runs monomial feeds and checks the decomposed digit stream
// against a reference model of the ring rotation, accumulation and rounding

`timescale 1ns/1ps

module tb_pbs_entry
  import pbs_pkg::*;
;

  // Several times the total length of all tests
  localparam int MAX_CYCLES = 4000;

  logic                clk;
  logic                s_rst_n;
  logic                ldg_cmd_vld;
  logic                ldg_cmd_rdy;
  logic [SLOT_W-1:0]   ldg_cmd_slot;
  logic                ldg_data_vld;
  logic                ldg_data_rdy;
  logic [COEF_W-1:0]   ldg_data;
  logic                ldg_done;
  logic                feed_cmd_vld;
  logic                feed_cmd_rdy;
  logic [SLOT_W-1:0]   feed_cmd_slot;
  logic [ROT_W-1:0]    feed_cmd_rot;
  logic                feed_cmd_first;
  logic                feed_cmd_last;
  logic [PBS_ID_W-1:0] feed_cmd_pbs_id;
  logic                feed_ack;
  logic                decomp_ntt_vld;
  logic                decomp_ntt_rdy;
  logic [DIGIT_W-1:0]  decomp_ntt_data;
  logic                decomp_ntt_sol;
  logic                decomp_ntt_eol;
  logic                decomp_ntt_eob;
  logic [PBS_ID_W-1:0] decomp_ntt_pbs_id;
  logic [CNT_W-1:0]    load_count;
  logic [CNT_W-1:0]    feed_count;
  logic [ERR_W-1:0]    error_flags;

  integer seed;
  int     errors;
  int     cycle_count;
  int     done_count;
  int     ack_count;
  int     loads_sent;
  int     feeds_sent;

  // Reference model of the GLWE RAM and the accumulator
  int     slot_model [SLOT_NB][POLY_N];
  int     acc_model  [POLY_N];

  pbs_entry_subsidiary dut (.*);

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  // Event pulses are counted on the rising edge, read on the falling edge
  always @(posedge clk) begin
    if (s_rst_n) begin
      if (ldg_done) begin
        done_count++;
      end
      if (feed_ack) begin
        ack_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("RESULT: FAIL");
      $fatal(1, "Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  // --------------------------------------------------------------------------
  // Checking and reference model
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
               expected);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Round to the top 8 bits, then split into balanced base-16 digits
  function automatic logic [DIGIT_W-1:0] expected_digit(input int coef, input int level);
    int v;
    int d0;
    int d1;
    int carry;
    v     = ((coef >> 8) + ((coef >> 7) % 2)) % 256;
    d0    = v % 16;
    carry = 0;
    if (d0 >= 8) begin
      d0    = d0 - 16;
      carry = 1;
    end
    d1 = v / 16 + carry;
    if (d1 >= 8) begin
      d1 = d1 - 16;
    end
    return (level == 0) ? DIGIT_W'(d0) : DIGIT_W'(d1);
  endfunction

  // Multiply by X^rot in the negacyclic ring, then overwrite or add
  function automatic void apply_feed(input int slot, input int rot, input bit first);
    int j;
    int p;
    int val;
    for (j = 0; j < POLY_N; j++) begin
      p   = (j + rot) % (2 * POLY_N);
      val = slot_model[slot][j];
      if (p >= POLY_N) begin
        p   = p - POLY_N;
        val = ((1 << COEF_W) - val) % (1 << COEF_W);
      end
      acc_model[p] = first ? val : (acc_model[p] + val) % (1 << COEF_W);
    end
  endfunction

  // --------------------------------------------------------------------------
  // Channel tasks
  // --------------------------------------------------------------------------
  task automatic load_slot(input int slot);
    logic [31:0] r;
    int          j;
    @(negedge clk);
    ldg_cmd_vld  = 1'b1;
    ldg_cmd_slot = SLOT_W'(slot);
    while (!ldg_cmd_rdy) @(negedge clk);
    @(negedge clk);
    ldg_cmd_vld = 1'b0;
    for (j = 0; j < POLY_N; j++) begin
      r                   = $random(seed);
      slot_model[slot][j] = int'(r[COEF_W-1:0]);
      ldg_data_vld        = 1'b1;
      ldg_data            = r[COEF_W-1:0];
      while (!ldg_data_rdy) @(negedge clk);
      @(negedge clk);
    end
    ldg_data_vld = 1'b0;
    loads_sent++;
    while (done_count < loads_sent) @(negedge clk);
    // A second pulse would show up here
    repeat (3) @(negedge clk);
    check_value("ldg_done count", 32'(done_count), 32'(loads_sent));
    check_value("load_count", 32'(load_count), 32'(loads_sent));
  endtask

  // Takes PBS_L digits per coefficient, with optional random back-pressure
  task automatic collect_digits(input logic [PBS_ID_W-1:0] pbs_id, input bit back_pressure);
    logic [31:0] r;
    int          n;
    int          idx;
    int          lvl;
    n = 0;
    while (n < PBS_L * POLY_N) begin
      @(negedge clk);
      r              = $random(seed);
      decomp_ntt_rdy = back_pressure ? r[0] : 1'b1;
      if (decomp_ntt_vld && decomp_ntt_rdy) begin
        idx = n / PBS_L;
        lvl = n % PBS_L;
        check_value("decomp_ntt_data", 32'(decomp_ntt_data),
                    32'(expected_digit(acc_model[idx], lvl)));
        check_value("decomp_ntt_sol", 32'(decomp_ntt_sol), 32'(lvl == 0));
        check_value("decomp_ntt_eol", 32'(decomp_ntt_eol), 32'(lvl == PBS_L - 1));
        check_value("decomp_ntt_eob", 32'(decomp_ntt_eob), 32'(idx == POLY_N - 1));
        check_value("decomp_ntt_pbs_id", 32'(decomp_ntt_pbs_id), 32'(pbs_id));
        n++;
      end
    end
    @(negedge clk);
    decomp_ntt_rdy = 1'b0;
  endtask

  task automatic feed(input int slot, input int rot, input bit first, input bit last,
                      input logic [PBS_ID_W-1:0] pbs_id, input bit back_pressure);
    apply_feed(slot, rot, first);
    @(negedge clk);
    feed_cmd_vld    = 1'b1;
    feed_cmd_slot   = SLOT_W'(slot);
    feed_cmd_rot    = ROT_W'(rot);
    feed_cmd_first  = first;
    feed_cmd_last   = last;
    feed_cmd_pbs_id = pbs_id;
    while (!feed_cmd_rdy) @(negedge clk);
    @(negedge clk);
    feed_cmd_vld = 1'b0;
    feeds_sent++;
    if (last) begin
      collect_digits(pbs_id, back_pressure);
    end
    while (ack_count < feeds_sent) @(negedge clk);
    check_value("feed_count", 32'(feed_count), 32'(feeds_sent));
    // Nothing left over after the full stream
    check_value("decomp_ntt_vld", 32'(decomp_ntt_vld), 32'(0));
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic idle_after_reset();
    check_value("ldg_cmd_rdy", 32'(ldg_cmd_rdy), 32'(1));
    check_value("feed_cmd_rdy", 32'(feed_cmd_rdy), 32'(1));
    check_value("ldg_data_rdy", 32'(ldg_data_rdy), 32'(0));
    check_value("decomp_ntt_vld", 32'(decomp_ntt_vld), 32'(0));
    check_value("ldg_done", 32'(ldg_done), 32'(0));
    check_value("feed_ack", 32'(feed_ack), 32'(0));
    check_value("load_count", 32'(load_count), 32'(0));
    check_value("feed_count", 32'(feed_count), 32'(0));
    check_value("error_flags", 32'(error_flags), 32'(0));
  endtask

  task automatic mixed_rotation_feeds();
    feed(1, 3, 1'b1, 1'b0, 4'h9, 1'b0);
    feed(0, 16, 1'b0, 1'b0, 4'h9, 1'b0);
    feed(1, 21, 1'b0, 1'b1, 4'h9, 1'b0);
  endtask

  task automatic stalled_digit_streams();
    feed(0, 7, 1'b1, 1'b1, 4'hc, 1'b1);
    feed(1, 30, 1'b0, 1'b1, 4'h3, 1'b1);
    check_value("error_flags", 32'(error_flags), 32'(0));
  endtask

  // Slot 3 is never loaded
  task automatic unloaded_slot_feeds();
    feed(3, 0, 1'b1, 1'b0, 4'h1, 1'b0);
    check_value("error_flags", 32'(error_flags), 32'(1 << ERR_FEED_SLOT));
    feed(0, 5, 1'b1, 1'b0, 4'h2, 1'b0);
    check_value("error_flags", 32'(error_flags), 32'(1 << ERR_FEED_SLOT));
  endtask

  initial begin
    seed            = 32'h52f5_04c9;
    errors          = 0;
    cycle_count     = 0;
    done_count      = 0;
    ack_count       = 0;
    loads_sent      = 0;
    feeds_sent      = 0;
    s_rst_n         = 1'b0;
    ldg_cmd_vld     = 1'b0;
    ldg_cmd_slot    = '0;
    ldg_data_vld    = 1'b0;
    ldg_data        = '0;
    feed_cmd_vld    = 1'b0;
    feed_cmd_slot   = '0;
    feed_cmd_rot    = '0;
    feed_cmd_first  = 1'b0;
    feed_cmd_last   = 1'b0;
    feed_cmd_pbs_id = '0;
    decomp_ntt_rdy  = 1'b0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;

    idle_after_reset();
    load_slot(0);
    load_slot(1);
    feed(0, 0, 1'b1, 1'b1, 4'h5, 1'b0);
    mixed_rotation_feeds();
    stalled_digit_streams();
    unloaded_slot_feeds();

    if (errors == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "Checks failed");
    end
  end

endmodule

/* project.f */
source/pbs_pkg.sv
source/glwe_loader.sv
source/glwe_ram.sv
source/mono_mult_acc.sv
source/decomp_balanced.sv
source/pbs_event_counter.sv
source/pbs_entry_subsidiary.sv
sim/pbs_entry_properties.sv
sim/tb_pbs_entry.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the entry side testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_pbs_entry \
  -f project.f -o tb_pbs_entry
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_pbs_entry
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
